/* rtl/spi_cmd_pkg.sv */
`default_nettype none

package spi_cmd_pkg;

   // one spi frame carries one command or one reply
   localparam int word_w = 32;
   localparam int payload_w = 24;
   localparam int op_w = word_w - payload_w;

   // command set, codes 8 and up are unknown
   typedef enum logic [op_w-1:0] {
      op_nop = 8'd0,
      op_init = 8'd1,
      op_wr_inv = 8'd2,
      op_rd_inv = 8'd3,
      op_wr_leds = 8'd4,
      op_rd_leds = 8'd5,
      op_wr_vec = 8'd6,
      op_rd_vec = 8'd7
   } cmd_op_e;

   // decoder FSM
   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_issue = 2'd1,
      st_wait = 2'd2,
      st_reply = 2'd3
   } dec_state_e;

endpackage

`default_nettype wire

/* rtl/target_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// request/acknowledge bus, one per target
interface target_bus_if import spi_cmd_pkg::*; ();

   logic req;
   cmd_op_e op;
   logic [payload_w-1:0] wdata;
   logic ack;
   logic [payload_w-1:0] rdata;

   modport host (
      output req, op, wdata,
      input ack, rdata
   );

   modport target (
      input req, op, wdata,
      output ack, rdata
   );

endinterface

`default_nettype wire

/* rtl/spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave import spi_cmd_pkg::*; #(
   parameter int sync_stages = 2
) (
   input wire clk,
   input wire rst,
   input wire sck,
   input wire ss,
   input wire mosi,
   output logic miso,
   output logic rx_valid,
   input wire rx_ready,
   output logic [word_w-1:0] rx_data,
   input wire tx_valid,
   output logic tx_ready,
   input wire [word_w-1:0] tx_data
);

   localparam int cnt_w = $clog2(word_w) + 1;
   localparam logic [cnt_w-1:0] full_cnt = cnt_w'(word_w);

   // {sck, ss, mosi} per stage
   logic [2:0] pin_sync [sync_stages];
   logic sck_s;
   logic ss_s;
   logic mosi_s;
   logic sck_d;
   logic ss_d;
   logic sck_rise;
   logic sck_fall;
   logic ss_rise;
   logic ss_fall;

   logic [cnt_w-1:0] bit_cnt;
   logic [word_w-1:0] shift_in;
   logic [word_w-1:0] shift_out;
   logic [word_w-1:0] slot;
   logic slot_full;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < sync_stages; i++) begin
            pin_sync[i] <= 3'b010;
         end
         sck_d <= 1'b0;
         ss_d <= 1'b1;
      end else begin
         pin_sync[0] <= {sck, ss, mosi};
         for (int i = 1; i < sync_stages; i++) begin
            pin_sync[i] <= pin_sync[i-1];
         end
         sck_d <= sck_s;
         ss_d <= ss_s;
      end
   end

   assign sck_s = pin_sync[sync_stages-1][2];
   assign ss_s = pin_sync[sync_stages-1][1];
   assign mosi_s = pin_sync[sync_stages-1][0];

   // sck edges only count inside a frame
   assign sck_rise = sck_s & ~sck_d & ~ss_s;
   assign sck_fall = ~sck_s & sck_d & ~ss_s;
   assign ss_rise = ss_s & ~ss_d;
   assign ss_fall = ~ss_s & ss_d;

   // receive side, counter saturates one past a full word
   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt <= '0;
         rx_valid <= 1'b0;
      end else begin
         if (ss_fall) begin
            bit_cnt <= '0;
         end else if (sck_rise && bit_cnt <= full_cnt) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         if (rx_valid && rx_ready) begin
            rx_valid <= 1'b0;
         end else if (ss_rise && bit_cnt == full_cnt) begin
            rx_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         shift_in <= {shift_in[word_w-2:0], mosi_s};
      end
      if (ss_rise && bit_cnt == full_cnt && !rx_valid) begin
         rx_data <= shift_in;
      end
   end

   // transmit side
   always_ff @(posedge clk) begin
      if (rst) begin
         shift_out <= '0;
         slot_full <= 1'b0;
      end else begin
         if (ss_fall) begin
            shift_out <= slot_full ? slot : '0;
            slot_full <= 1'b0;
         end else if (sck_fall) begin
            shift_out <= {shift_out[word_w-2:0], 1'b0};
         end
         // a write in the load cycle refills the emptied slot
         if (tx_valid && tx_ready) begin
            slot_full <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_valid && tx_ready) begin
         slot <= tx_data;
      end
   end

   assign tx_ready = ~slot_full;
   assign miso = shift_out[word_w-1];

endmodule

`default_nettype wire

/* rtl/cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder import spi_cmd_pkg::*; (
   input wire clk,
   input wire rst,
   input wire rx_valid,
   output logic rx_ready,
   input wire [word_w-1:0] rx_data,
   output logic tx_valid,
   input wire tx_ready,
   output logic [word_w-1:0] tx_data,
   target_bus_if.host regs,
   target_bus_if.host vec
);

   dec_state_e state;

   logic [op_w-1:0] rx_op;
   logic [payload_w-1:0] rx_payload;
   logic rx_to_regs;
   logic rx_to_vec;
   logic rx_known;

   logic [op_w-1:0] op_q;
   logic [payload_w-1:0] payload_q;
   logic [payload_w-1:0] reply_q;
   logic regs_pend;
   logic vec_pend;
   logic regs_left;
   logic vec_left;
   logic is_read;

   assign rx_op = rx_data[word_w-1:payload_w];
   assign rx_payload = rx_data[payload_w-1:0];

   // routing of the incoming opcode
   always_comb begin
      rx_to_regs = 1'b0;
      rx_to_vec = 1'b0;
      rx_known = 1'b1;
      case (rx_op)
         op_nop: ;
         op_init: begin
            rx_to_regs = 1'b1;
            rx_to_vec = 1'b1;
         end
         op_wr_inv, op_rd_inv, op_wr_leds, op_rd_leds: rx_to_regs = 1'b1;
         op_wr_vec, op_rd_vec: rx_to_vec = 1'b1;
         default: rx_known = 1'b0;
      endcase
   end

   assign is_read = (op_q == op_rd_inv) || (op_q == op_rd_leds) || (op_q == op_rd_vec);

   // acks still missing after this cycle
   assign regs_left = regs_pend & ~regs.ack;
   assign vec_left = vec_pend & ~vec.ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         regs_pend <= 1'b0;
         vec_pend <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (rx_valid) begin
                  regs_pend <= rx_to_regs;
                  vec_pend <= rx_to_vec;
                  // nop and unknown codes answer at once
                  state <= (rx_to_regs || rx_to_vec) ? st_issue : st_reply;
               end
            end
            st_issue: state <= st_wait;
            st_wait: begin
               regs_pend <= regs_left;
               vec_pend <= vec_left;
               if (!regs_left && !vec_left) begin
                  state <= st_reply;
               end
            end
            st_reply: begin
               if (tx_ready) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // command fields and reply payload
   always_ff @(posedge clk) begin
      if (state == st_idle && rx_valid) begin
         op_q <= rx_op;
         payload_q <= rx_payload;
         reply_q <= rx_known ? '0 : '1;
      end else if (state == st_wait && is_read) begin
         if (regs_pend && regs.ack) begin
            reply_q <= regs.rdata;
         end
         if (vec_pend && vec.ack) begin
            reply_q <= vec.rdata;
         end
      end
   end

   assign regs.req = (state == st_issue) && regs_pend;
   assign regs.op = cmd_op_e'(op_q);
   assign regs.wdata = payload_q;
   assign vec.req = (state == st_issue) && vec_pend;
   assign vec.op = cmd_op_e'(op_q);
   assign vec.wdata = payload_q;

   assign rx_ready = (state == st_idle);
   assign tx_valid = (state == st_reply);
   assign tx_data = {op_q, reply_q};

endmodule

`default_nettype wire

/* rtl/ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import spi_cmd_pkg::*; (
   input wire clk,
   input wire rst,
   target_bus_if.target bus,
   output logic [2:0] leds
);

   logic [15:0] inv_q;
   logic [2:0] leds_q;
   logic ack_q;
   logic [payload_w-1:0] rdata_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         inv_q <= '0;
         leds_q <= '0;
         ack_q <= 1'b0;
      end else begin
         // every request is acked, whatever the opcode
         ack_q <= bus.req;
         if (bus.req) begin
            case (bus.op)
               op_init: begin
                  inv_q <= '0;
                  leds_q <= '0;
               end
               op_wr_inv: inv_q <= ~bus.wdata[15:0];
               op_wr_leds: leds_q <= bus.wdata[2:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bus.req) begin
         case (bus.op)
            op_rd_inv: rdata_q <= payload_w'(inv_q);
            op_rd_leds: rdata_q <= payload_w'(leds_q);
            default: rdata_q <= '0;
         endcase
      end
   end

   assign bus.ack = ack_q;
   assign bus.rdata = rdata_q;
   assign leds = leds_q;

endmodule

`default_nettype wire

/* rtl/vec_store.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_store import spi_cmd_pkg::*; #(
   parameter int vec_depth = 4
) (
   input wire clk,
   input wire rst,
   target_bus_if.target bus
);

   localparam int ptr_w = (vec_depth > 1) ? $clog2(vec_depth) : 1;
   localparam logic [ptr_w-1:0] last_addr = ptr_w'(vec_depth - 1);

   logic [payload_w-1:0] mem [vec_depth];
   logic [payload_w-1:0] rd_q;
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;

   // clear walk, started by reset and by op_init
   logic clr_active;
   logic clr_ack;
   logic [ptr_w-1:0] clr_addr;
   logic clr_last;

   logic req_d;
   logic rd_d;
   logic ack_q;
   logic [payload_w-1:0] rdata_q;

   assign clr_last = clr_active && (clr_addr == last_addr);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         clr_active <= 1'b1;
         clr_ack <= 1'b0;
         clr_addr <= '0;
         req_d <= 1'b0;
         rd_d <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         req_d <= bus.req && (bus.op != op_init);
         rd_d <= bus.req && (bus.op == op_rd_vec);
         ack_q <= req_d || (clr_last && clr_ack);
         if (clr_active) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_last) begin
               clr_active <= 1'b0;
               clr_ack <= 1'b0;
            end
         end
         if (bus.req) begin
            case (bus.op)
               op_init: begin
                  wr_ptr <= '0;
                  rd_ptr <= '0;
                  clr_active <= 1'b1;
                  clr_ack <= 1'b1;
                  clr_addr <= '0;
               end
               op_wr_vec: wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
               op_rd_vec: rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
               default: ;
            endcase
         end
      end
   end

   // inferred RAM, one write port and a registered read
   always_ff @(posedge clk) begin
      if (clr_active) begin
         mem[clr_addr] <= '0;
      end else if (bus.req && bus.op == op_wr_vec) begin
         mem[wr_ptr] <= bus.wdata;
      end
      rd_q <= mem[rd_ptr];
   end

   // output stage
   always_ff @(posedge clk) begin
      rdata_q <= rd_d ? rd_q : '0;
   end

   assign bus.ack = ack_q;
   assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/spi_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_top #(
   parameter int sync_stages = 2,
   parameter int vec_depth = 4
) (
   input wire clk,
   input wire rst,
   input wire spi_sck,
   input wire spi_ss,
   input wire spi_mosi,
   output logic spi_miso,
   output logic [2:0] leds
);

   logic rx_valid;
   logic rx_ready;
   logic [31:0] rx_data;
   logic tx_valid;
   logic tx_ready;
   logic [31:0] tx_data;

   target_bus_if regs_bus ();
   target_bus_if vec_bus ();

   spi_slave #(
      .sync_stages(sync_stages)
   ) u_spi_slave (
      .clk(clk),
      .rst(rst),
      .sck(spi_sck),
      .ss(spi_ss),
      .mosi(spi_mosi),
      .miso(spi_miso),
      .rx_valid(rx_valid),
      .rx_ready(rx_ready),
      .rx_data(rx_data),
      .tx_valid(tx_valid),
      .tx_ready(tx_ready),
      .tx_data(tx_data)
   );

   cmd_decoder u_cmd_decoder (
      .clk(clk),
      .rst(rst),
      .rx_valid(rx_valid),
      .rx_ready(rx_ready),
      .rx_data(rx_data),
      .tx_valid(tx_valid),
      .tx_ready(tx_ready),
      .tx_data(tx_data),
      .regs(regs_bus.host),
      .vec(vec_bus.host)
   );

   ctrl_regs u_ctrl_regs (
      .clk(clk),
      .rst(rst),
      .bus(regs_bus.target),
      .leds(leds)
   );

   vec_store #(
      .vec_depth(vec_depth)
   ) u_vec_store (
      .clk(clk),
      .rst(rst),
      .bus(vec_bus.target)
   );

endmodule

`default_nettype wire

/* bench/tb_spi_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_cmd import spi_cmd_pkg::*; ();

   localparam int half_sck = 8;
   localparam int idle_gap = 20;
   localparam int vec_slots = 4;
   localparam int n_inv = 20;
   localparam int n_leds = 4;
   localparam int n_mix = 40;
   // reset probe, inv pairs, leds pairs, vector run, init run, mix, final flush
   localparam int n_frames = 1 + 2 * n_inv + 2 * n_leds + 10 + 7 + n_mix + 1;
   localparam int frame_cycles = 1 + half_sck * (2 * word_w + 1) + idle_gap;
   localparam int watchdog_cycles = n_frames * frame_cycles * 2;

   logic clk;
   logic rst;
   logic spi_sck;
   logic spi_ss;
   logic spi_mosi;
   logic spi_miso;
   logic [2:0] leds;

   // reference model state
   logic [15:0] m_inv = '0;
   logic [2:0] m_leds = '0;
   logic [23:0] m_vec [vec_slots] = '{default: '0};
   int m_wr = 0;
   int m_rd = 0;

   logic [31:0] rng_state = 32'heea1;
   logic [31:0] last_exp = '0;

   // pending checks filled by the stimulus and drained by the compare process
   logic [31:0] got_q [$];
   logic [31:0] exp_q [$];
   string name_q [$];
   int n_queued = 0;
   int n_done = 0;
   int errors = 0;
   logic [31:0] cmp_got;
   logic [31:0] cmp_exp;
   string cmp_name;

   spi_cmd_top u_dut (
      .clk(clk),
      .rst(rst),
      .spi_sck(spi_sck),
      .spi_ss(spi_ss),
      .spi_mosi(spi_mosi),
      .spi_miso(spi_miso),
      .leds(leds)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // returns the expected reply word and updates the model state
   function automatic logic [31:0] model_reply(input logic [31:0] cmd);
      logic [7:0] op;
      logic [23:0] p;
      logic [23:0] res;
      op = cmd[31:24];
      p = cmd[23:0];
      res = '0;
      case (op)
         op_nop: ;
         op_init: begin
            m_inv = '0;
            m_leds = '0;
            m_wr = 0;
            m_rd = 0;
            for (int i = 0; i < vec_slots; i++) begin
               m_vec[i] = '0;
            end
         end
         op_wr_inv: m_inv = ~p[15:0];
         op_rd_inv: res = {8'h00, m_inv};
         op_wr_leds: m_leds = p[2:0];
         op_rd_leds: res = {21'h0, m_leds};
         op_wr_vec: begin
            m_vec[m_wr] = p;
            m_wr = (m_wr + 1) % vec_slots;
         end
         op_rd_vec: begin
            res = m_vec[m_rd];
            m_rd = (m_rd + 1) % vec_slots;
         end
         default: res = 24'hffffff;
      endcase
      return {op, res};
   endfunction

   task automatic queue_check(input string name, input logic [31:0] got, input logic [31:0] exp);
      got_q.push_back(got);
      exp_q.push_back(exp);
      name_q.push_back(name);
      n_queued++;
   endtask

   // spi mode 0 master sending one 32-bit frame msb first
   task automatic spi_frame(input logic [31:0] mosi_word, output logic [31:0] miso_word);
      @(posedge clk);
      spi_ss <= 1'b0;
      spi_mosi <= mosi_word[31];
      repeat (half_sck) @(posedge clk);
      for (int i = 31; i >= 0; i--) begin
         spi_sck <= 1'b1;
         // miso settled well before this edge
         miso_word[i] = spi_miso;
         repeat (half_sck) @(posedge clk);
         spi_sck <= 1'b0;
         if (i > 0) begin
            spi_mosi <= mosi_word[i-1];
         end
         repeat (half_sck) @(posedge clk);
      end
      spi_ss <= 1'b1;
      repeat (idle_gap) @(posedge clk);
   endtask

   // miso of this frame answers the previous command
   task automatic send_cmd(input logic [7:0] op, input logic [23:0] payload);
      logic [31:0] cmd;
      logic [31:0] miso_word;
      cmd = {op, payload};
      spi_frame(cmd, miso_word);
      queue_check("spi_miso", miso_word, last_exp);
      last_exp = model_reply(cmd);
      if (op == op_wr_leds || op == op_init) begin
         queue_check("leds", 32'(leds), 32'(m_leds));
      end
   endtask

   always @(posedge clk) begin
      if (got_q.size() > 0) begin
         cmp_got = got_q.pop_front();
         cmp_exp = exp_q.pop_front();
         cmp_name = name_q.pop_front();
         if (cmp_got !== cmp_exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h",
                     $time, cmp_name, cmp_got, cmp_exp);
            errors++;
         end
         n_done++;
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
      $display("checks: %0d, errors: %0d", n_done, errors);
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      logic [31:0] r;
      logic [7:0] op;
      rst = 1'b1;
      spi_sck = 1'b0;
      spi_ss = 1'b1;
      spi_mosi = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      // let the vector clear walk finish
      repeat (10) @(posedge clk);

      queue_check("leds", 32'(leds), 32'h0);
      send_cmd(op_nop, 24'h0);

      for (int i = 0; i < n_inv; i++) begin
         send_cmd(op_wr_inv, 24'(next_rand() >> 8));
         send_cmd(op_rd_inv, 24'h0);
      end

      for (int i = 0; i < n_leds; i++) begin
         send_cmd(op_wr_leds, 24'(next_rand() >> 8));
         send_cmd(op_rd_leds, 24'h0);
      end

      // six writes wrap the write pointer past the end
      for (int i = 0; i < 6; i++) begin
         send_cmd(op_wr_vec, 24'(next_rand() >> 8));
      end
      for (int i = 0; i < 4; i++) begin
         send_cmd(op_rd_vec, 24'h0);
      end

      send_cmd(op_init, 24'h0);
      send_cmd(op_rd_inv, 24'h0);
      send_cmd(op_rd_leds, 24'h0);
      for (int i = 0; i < 4; i++) begin
         send_cmd(op_rd_vec, 24'h0);
      end

      // roughly one in four is an unknown code
      for (int i = 0; i < n_mix; i++) begin
         r = next_rand();
         if (r[31:30] == 2'b00) begin
            op = 8'(8 + (r[15:8] % 248));
         end else begin
            op = {5'b0, r[26:24]};
         end
         send_cmd(op, r[23:0]);
      end

      // collects the reply to the last command
      send_cmd(op_nop, 24'h0);

      while (n_done != n_queued) begin
         @(posedge clk);
      end
      $display("checks: %0d, errors: %0d", n_done, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
rtl/spi_cmd_pkg.sv
rtl/target_bus_if.sv
rtl/spi_slave.sv
rtl/cmd_decoder.sv
rtl/ctrl_regs.sv
rtl/vec_store.sv
rtl/spi_cmd_top.sv
bench/tb_spi_cmd.sv

/* Makefile */
TOP = tb_spi_cmd

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
